// ==== Bender.yml ====
package:
  name: periph_subsys

sources:
  - files:
      - common/sys_bus_pkg.sv
      - common/dev_bus_if.sv
      - bus/bus_decoder.sv
      - verilog/gpio_regs.sv
      - verilog/mtimer.sv
      - verilog/periph_subsys_top.sv
  - target: test
    files:
      - tb/tb_ext_ram.sv
      - tb/tb_periph_subsys.sv

// ==== bus/bus_decoder.sv ====
//////////////////////////////
// Bus decoder
// Routes host accesses to RAM, GPIO or timer
//////////////////////////////

`timescale 1ns/1ns

module bus_decoder (
  input  logic               clk_sys_i,
  input  logic               rst_sys_ni,

  input  logic               host_req_i,
  input  sys_bus_pkg::addr_t host_addr_i,
  input  logic               host_we_i,
  input  sys_bus_pkg::strb_t host_be_i,
  input  sys_bus_pkg::data_t host_wdata_i,
  output logic               host_gnt_o,
  output logic               host_rvalid_o,
  output sys_bus_pkg::data_t host_rdata_o,
  output logic               host_err_o,

  dev_bus_if.decoder         gpio_bus,
  dev_bus_if.decoder         timer_bus,

  output logic               mem_req_o,
  output logic               mem_we_o,
  output sys_bus_pkg::strb_t mem_be_o,
  output sys_bus_pkg::addr_t mem_addr_o,
  output sys_bus_pkg::data_t mem_wdata_o,
  input  logic               mem_rvalid_i,
  input  sys_bus_pkg::data_t mem_rdata_i
);
  import sys_bus_pkg::*;

  logic  ram_hit, gpio_hit, timer_hit;
  logic  any_hit;
  dev_e  dev_sel;
  logic  out_valid_q;  // Access in flight
  logic  out_err_q;    // In-flight access hit nothing
  dev_e  out_dev_q;
  logic  dev_rvalid [NrDevices];
  data_t dev_rdata  [NrDevices];
  logic  rsp_valid;

  // Base/mask match
  assign ram_hit   = (host_addr_i & RamMask) == RamBase;
  assign gpio_hit  = (host_addr_i & GpioMask) == GpioBase;
  assign timer_hit = (host_addr_i & TimerMask) == TimerBase;
  assign any_hit   = ram_hit | gpio_hit | timer_hit;

  // Regions are disjoint, RAM is the fallback encoding
  always_comb begin
    dev_sel = DevRam;
    if (gpio_hit) begin
      dev_sel = DevGpio;
    end else if (timer_hit) begin
      dev_sel = DevTimer;
    end
  end

  assign host_gnt_o = host_req_i & ~out_valid_q;

  // Request strobes, only the selected device sees req
  assign mem_req_o     = host_gnt_o & ram_hit;
  assign gpio_bus.req  = host_gnt_o & gpio_hit;
  assign timer_bus.req = host_gnt_o & timer_hit;

  // Payload goes to every device unqualified
  assign mem_we_o    = host_we_i;
  assign mem_be_o    = host_be_i;
  assign mem_addr_o  = host_addr_i;
  assign mem_wdata_o = host_wdata_i;

  assign gpio_bus.addr   = host_addr_i;
  assign gpio_bus.we     = host_we_i;
  assign gpio_bus.be     = host_be_i;
  assign gpio_bus.wdata  = host_wdata_i;
  assign timer_bus.addr  = host_addr_i;
  assign timer_bus.we    = host_we_i;
  assign timer_bus.be    = host_be_i;
  assign timer_bus.wdata = host_wdata_i;

  assign dev_rvalid[DevRam]   = mem_rvalid_i;
  assign dev_rdata[DevRam]    = mem_rdata_i;
  assign dev_rvalid[DevGpio]  = gpio_bus.rvalid;
  assign dev_rdata[DevGpio]   = gpio_bus.rdata;
  assign dev_rvalid[DevTimer] = timer_bus.rvalid;
  assign dev_rdata[DevTimer]  = timer_bus.rdata;

  // Error answer comes out of the flag the cycle after grant
  assign rsp_valid     = out_valid_q & (out_err_q | dev_rvalid[out_dev_q]);
  assign host_rvalid_o = rsp_valid;
  assign host_err_o    = out_valid_q & out_err_q;
  assign host_rdata_o  = out_err_q ? '0 : dev_rdata[out_dev_q];

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      out_valid_q <= 1'b0;
      out_err_q   <= 1'b0;
      out_dev_q   <= DevRam;
    end else if (host_gnt_o) begin
      out_valid_q <= 1'b1;
      out_err_q   <= ~any_hit;
      out_dev_q   <= dev_sel;
    end else if (rsp_valid) begin
      out_valid_q <= 1'b0;
      out_err_q   <= 1'b0;
    end
  end

  // No second grant before the first access has been answered
  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_gnt_o |=> (!host_gnt_o until_with host_rvalid_o));

  // Devices and RAM only answer an access in flight
  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    (mem_rvalid_i | gpio_bus.rvalid | timer_bus.rvalid) |-> out_valid_q);

endmodule

// ==== common/dev_bus_if.sv ====
//////////////////////////////
// Device-side bus interface
// Single-cycle req, response one cycle later
//////////////////////////////

`timescale 1ns/1ns

interface dev_bus_if;
  import sys_bus_pkg::*;

  logic  req;     // One cycle per access
  addr_t addr;
  logic  we;
  strb_t be;
  data_t wdata;
  logic  rvalid;  // Cycle after req
  data_t rdata;

  // Decoder side
  modport decoder (
    output req, addr, we, be, wdata,
    input  rvalid, rdata
  );

  // Device side
  modport device (
    input  req, addr, we, be, wdata,
    output rvalid, rdata
  );

endinterface

// ==== common/sys_bus_pkg.sv ====
//////////////////////////////
// System bus package
// Bus types, memory map and device register offsets
//////////////////////////////

package sys_bus_pkg;

  // Bus word types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // One enable per data byte

  // Decoded devices
  typedef enum logic [1:0] {
    DevRam,
    DevGpio,
    DevTimer
  } dev_e;

  localparam int NrDevices = 3;

  // Memory map
  localparam addr_t RamBase   = 32'h0010_0000;
  localparam addr_t RamMask   = 32'hFFFF_0000;  // 64 KiB
  localparam addr_t GpioBase  = 32'h8000_0000;
  localparam addr_t GpioMask  = 32'hFFFF_F000;  // 4 KiB
  localparam addr_t TimerBase = 32'h8000_2000;
  localparam addr_t TimerMask = 32'hFFFF_F000;  // 4 KiB

  // Low address bits seen by the register devices
  localparam int RegOffsetBits = 4;

  // GPIO registers
  localparam logic [RegOffsetBits-1:0] GpioOutOffset = 4'h0;
  localparam logic [RegOffsetBits-1:0] GpioInOffset  = 4'h4;

  // Timer registers, 64-bit values split into halves
  localparam logic [RegOffsetBits-1:0] MtimeLoOffset    = 4'h0;
  localparam logic [RegOffsetBits-1:0] MtimeHiOffset    = 4'h4;
  localparam logic [RegOffsetBits-1:0] MtimecmpLoOffset = 4'h8;
  localparam logic [RegOffsetBits-1:0] MtimecmpHiOffset = 4'hC;

endpackage

// ==== src.f ====
common/sys_bus_pkg.sv
common/dev_bus_if.sv
bus/bus_decoder.sv
verilog/gpio_regs.sv
verilog/mtimer.sv
verilog/periph_subsys_top.sv
tb/tb_ext_ram.sv
tb/tb_periph_subsys.sv

// ==== tb/tb_ext_ram.sv ====
//////////////////////////////
// External RAM model
// Random 0..3 cycle response delay
//////////////////////////////

`timescale 1ns/1ns

module tb_ext_ram #(
  parameter int Words = 16384  // 64 KiB region
) (
  input  logic        clk_sys_i,
  input  logic        rst_sys_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  logic [31:0] mem [Words];
  logic [31:0] lfsr_q, lfsr_1, lfsr_2;
  logic        pending_q;
  logic [1:0]  wait_q;
  logic [13:0] idx;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Fill with the inverted byte address of each word
  initial begin
    for (int i = 0; i < Words; i++) mem[i] = ~(32'h0010_0000 + 32'(i) * 4);
  end

  assign idx      = addr_i[15:2];
  assign lfsr_1   = lfsr_next(lfsr_q);  // One step per delay bit
  assign lfsr_2   = lfsr_next(lfsr_1);
  assign rvalid_o = pending_q && wait_q == 2'd0;

  always @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      pending_q <= 1'b0;
      wait_q    <= 2'd0;
      lfsr_q    <= 32'hc5c38d9b;
      rdata_o   <= '0;
    end else if (req_i) begin
      pending_q <= 1'b1;
      wait_q    <= {lfsr_1[0], lfsr_2[0]};
      lfsr_q    <= lfsr_2;
      rdata_o   <= we_i ? 32'h0 : mem[idx];  // Writes answer zero
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end else if (rvalid_o) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      wait_q <= wait_q - 2'd1;
    end
  end

endmodule

// ==== tb/tb_periph_subsys.sv ====
//////////////////////////////
// Peripheral subsystem testbench
// Table-driven host accesses and checks
//////////////////////////////

`timescale 1ns/1ns

module tb_periph_subsys;

  localparam int GpiWidth       = 8;
  localparam int GpoWidth       = 16;
  localparam int NumRows        = 19;
  localparam int WatchdogCycles = NumRows * 20 + 200;

  logic                clk_sys, rst_sys_n;
  logic                host_req, host_we, host_gnt, host_rvalid, host_err;
  logic [31:0]         host_addr, host_wdata, host_rdata;
  logic [3:0]          host_be;
  logic                mem_req, mem_we, mem_rvalid;
  logic [3:0]          mem_be;
  logic [31:0]         mem_addr, mem_wdata, mem_rdata;
  logic [GpiWidth-1:0] gp_i;
  logic [GpoWidth-1:0] gp_o, gpo_model;
  logic                timer_irq;

  int err_count = 0;
  int chk_count = 0;
  int rsp_count = 0;
  int acc_count = 0;

  // Stimulus and expected response per row
  logic [31:0] row_addr  [NumRows];
  logic        row_we    [NumRows];
  logic [3:0]  row_be    [NumRows];
  logic [31:0] row_wdata [NumRows];
  logic [31:0] row_rdata [NumRows];
  logic        row_err   [NumRows];

  periph_subsys_top #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) u_dut (
    .clk_sys_i     (clk_sys),
    .rst_sys_ni    (rst_sys_n),
    .host_req_i    (host_req),
    .host_addr_i   (host_addr),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_be_o      (mem_be),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .gp_i          (gp_i),
    .gp_o          (gp_o),
    .timer_irq_o   (timer_irq)
  );

  tb_ext_ram u_ram (
    .clk_sys_i  (clk_sys),
    .rst_sys_ni (rst_sys_n),
    .req_i      (mem_req),
    .we_i       (mem_we),
    .be_i       (mem_be),
    .addr_i     (mem_addr),
    .wdata_i    (mem_wdata),
    .rvalid_o   (mem_rvalid),
    .rdata_o    (mem_rdata)
  );

  initial begin
    clk_sys = 1'b0;
    forever #2 clk_sys = ~clk_sys;
  end

  // Response pulses, compared with the access count at the end
  always @(negedge clk_sys) begin
    if (rst_sys_n && host_rvalid) rsp_count++;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_sys);
    $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic set_row(input int i, input logic [31:0] addr, input logic we,
                         input logic [3:0] be, input logic [31:0] wdata,
                         input logic [31:0] rdata, input logic err);
    row_addr[i]  = addr;
    row_we[i]    = we;
    row_be[i]    = be;
    row_wdata[i] = wdata;
    row_rdata[i] = rdata;
    row_err[i]   = err;
  endtask

  task automatic fill_table();
    set_row(0,  32'h8000_0000, 1, 4'hF, 32'hDEAD_BEEF, 32'h0000_0000, 0);  // GPIO out
    set_row(1,  32'h8000_0000, 0, 4'hF, 32'h0,         32'h0000_BEEF, 0);
    set_row(2,  32'h8000_0000, 1, 4'h1, 32'h1234_5678, 32'h0000_0000, 0);
    set_row(3,  32'h8000_0000, 0, 4'hF, 32'h0,         32'h0000_BE78, 0);
    set_row(4,  32'h8000_0004, 0, 4'hF, 32'h0,         32'h0000_00A5, 0);  // GPIO in
    set_row(5,  32'h8000_0004, 1, 4'hF, 32'h0000_00FF, 32'h0000_0000, 0);
    set_row(6,  32'h8000_0004, 0, 4'hF, 32'h0,         32'h0000_00A5, 0);
    set_row(7,  32'h0010_0000, 1, 4'hF, 32'h1111_2222, 32'h0000_0000, 0);  // RAM
    set_row(8,  32'h0010_0004, 1, 4'hF, 32'hCAFE_F00D, 32'h0000_0000, 0);
    set_row(9,  32'h0010_0000, 1, 4'h6, 32'hAABB_CCDD, 32'h0000_0000, 0);
    set_row(10, 32'h0010_0000, 0, 4'hF, 32'h0,         32'h11BB_CC22, 0);
    set_row(11, 32'h0010_0004, 0, 4'hF, 32'h0,         32'hCAFE_F00D, 0);
    set_row(12, 32'h0010_FFFC, 1, 4'hF, 32'h0BAD_CAFE, 32'h0000_0000, 0);
    set_row(13, 32'h0010_FFFC, 0, 4'hF, 32'h0,         32'h0BAD_CAFE, 0);
    set_row(14, 32'h4000_0000, 0, 4'hF, 32'h0,         32'h0000_0000, 1);  // Unmapped
    set_row(15, 32'h8000_1000, 1, 4'hF, 32'h0000_0001, 32'h0000_0000, 1);
    set_row(16, 32'h0010_0004, 0, 4'hF, 32'h0,         32'hCAFE_F00D, 0);
    set_row(17, 32'h8000_2004, 0, 4'hF, 32'h0,         32'h0000_0000, 0);  // Timer
    set_row(18, 32'h8000_200C, 0, 4'hF, 32'h0,         32'hFFFF_FFFF, 0);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    chk_count++;
    assert (got === exp) else begin
      err_count++;
      $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    chk_count++;
    assert (cond === 1'b1) else begin
      err_count++;
      $display("At %0t ns: %s", $time, what);
    end
  endtask

  function automatic logic is_ram_addr(input logic [31:0] addr);
    return addr[31:16] == 16'h0010;
  endfunction

  // One host access, latency counted in cycles after the grant
  task automatic bus_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int lat);
    @(negedge clk_sys);
    host_req   = 1'b1;
    host_addr  = addr;
    host_we    = we;
    host_be    = be;
    host_wdata = wdata;
    #1;
    while (!host_gnt) begin
      @(negedge clk_sys);
      #1;
    end
    acc_count++;
    @(negedge clk_sys);
    host_req = 1'b0;
    lat = 1;
    while (!host_rvalid) begin
      @(negedge clk_sys);
      lat++;
    end
    rdata = host_rdata;
    err   = host_err;
  endtask

  task automatic run_timer_checks();
    logic [31:0] t0, t1, rdata;
    logic        err;
    int          lat;
    bus_access(32'h8000_2000, 0, 4'hF, 32'h0, t0, err, lat);
    bus_access(32'h8000_2000, 0, 4'hF, 32'h0, t1, err, lat);
    check_true(t1 > t0, "mtime lower half did not grow between two reads");
    bus_access(32'h8000_2004, 0, 4'hF, 32'h0, rdata, err, lat);
    check_val("host_rdata_o", rdata, 32'h0);
    bus_access(32'h8000_200C, 1, 4'hF, 32'h0, rdata, err, lat);
    bus_access(32'h8000_2008, 1, 4'hF, t1 + 32'd50, rdata, err, lat);
    check_val("timer_irq_o", timer_irq, 1'b0);  // Compare point still ahead
    repeat (100) @(negedge clk_sys);
    check_val("timer_irq_o", timer_irq, 1'b1);
    bus_access(32'h8000_2008, 1, 4'hF, 32'hFFFF_FFFF, rdata, err, lat);
    bus_access(32'h8000_200C, 1, 4'hF, 32'hFFFF_FFFF, rdata, err, lat);
    repeat (2) @(negedge clk_sys);
    check_val("timer_irq_o", timer_irq, 1'b0);
  endtask

  initial begin : main
    logic [31:0] rdata;
    logic        err;
    int          lat;
    host_req   = 1'b0;
    host_addr  = '0;
    host_we    = 1'b0;
    host_be    = '0;
    host_wdata = '0;
    gp_i       = '0;
    gpo_model  = '0;
    rst_sys_n  = 1'b0;
    fill_table();
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    rst_sys_n = 1'b1;
    @(negedge clk_sys);
    gp_i = 8'hA5;  // Settles through the synchronizer during the first rows
    #1;
    check_val("gp_o", gp_o, 32'h0);
    check_val("timer_irq_o", timer_irq, 1'b0);
    check_true(rsp_count == 0, "host_rvalid_o pulsed before any access");

    for (int i = 0; i < NumRows; i++) begin
      bus_access(row_addr[i], row_we[i], row_be[i], row_wdata[i], rdata, err, lat);
      check_val("host_rdata_o", rdata, row_rdata[i]);
      check_val("host_err_o", err, row_err[i]);
      if (is_ram_addr(row_addr[i])) begin
        check_true(lat >= 1 && lat <= 4, "RAM response latency out of range");
      end else begin
        check_val("host_rvalid_o latency", lat, 32'd1);
      end
      if (row_addr[i] == 32'h8000_0000 && row_we[i]) begin
        for (int lane = 0; lane < GpoWidth / 8; lane++) begin
          if (row_be[i][lane]) gpo_model[8*lane +: 8] = row_wdata[i][8*lane +: 8];
        end
      end
      check_val("gp_o", gp_o, gpo_model);
    end

    run_timer_checks();

    repeat (2) @(negedge clk_sys);
    #1;
    check_true(rsp_count == acc_count, "number of responses differs from number of accesses");
    $display("Checks: %0d, errors: %0d", chk_count, err_count);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/gpio_regs.sv ====
//////////////////////////////
// GPIO registers
// Byte-writable outputs, synchronized inputs
//////////////////////////////

`timescale 1ns/1ns

module gpio_regs #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  dev_bus_if.device           bus,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o
);
  import sys_bus_pkg::*;

  logic [RegOffsetBits-1:0] reg_off;
  logic [GpoWidth-1:0]      gpo_q;
  logic [GpiWidth-1:0]      gpi_meta_q, gpi_q;  // Two-flop synchronizer
  data_t                    rdata_q;
  logic                     rvalid_q;

  if (GpiWidth > 32 || GpoWidth > 32) begin : g_width_check
    $error("GPIO widths must not exceed the bus width");
  end

  assign reg_off = bus.addr[RegOffsetBits-1:0];

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_q      <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_q      <= gpi_meta_q;
      rvalid_q   <= bus.req;
      if (bus.req && bus.we && reg_off == GpioOutOffset) begin
        for (int b = 0; b < GpoWidth; b++) begin
          if (bus.be[b/8]) gpo_q[b] <= bus.wdata[b];  // Byte-lane merge
        end
      end
    end
  end

  // Writes answer zero, input register ignores them
  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      if (bus.we) rdata_q <= '0;
      else if (reg_off == GpioOutOffset) rdata_q <= data_t'(gpo_q);
      else if (reg_off == GpioInOffset) rdata_q <= data_t'(gpi_q);
      else rdata_q <= '0;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign gp_o       = gpo_q;

  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus.req |=> bus.rvalid ##1 !bus.rvalid || $past(bus.req));

endmodule

// ==== verilog/mtimer.sv ====
//////////////////////////////
// Machine timer
// 64-bit mtime/mtimecmp with level interrupt
//////////////////////////////

`timescale 1ns/1ns

module mtimer (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  dev_bus_if.device bus,

  output logic      timer_irq_o
);
  import sys_bus_pkg::*;

  logic [RegOffsetBits-1:0] reg_off;
  logic [63:0]              mtime_q, mtime_d;
  logic [63:0]              mtimecmp_q, mtimecmp_d;
  logic                     irq_q;
  logic                     rvalid_q;
  data_t                    rdata_q;
  logic                     wr_en;

  // Byte-enable merge of one 32-bit half
  function automatic data_t merge_be(data_t old_val, data_t new_val, strb_t be);
    data_t res;
    res = old_val;
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (be[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  assign reg_off = bus.addr[RegOffsetBits-1:0];
  assign wr_en   = bus.req & bus.we;

  // Bus write wins over the increment for the half it touches
  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr_en) begin
      case (reg_off)
        MtimeLoOffset:    mtime_d[31:0]     = merge_be(mtime_q[31:0], bus.wdata, bus.be);
        MtimeHiOffset:    mtime_d[63:32]    = merge_be(mtime_q[63:32], bus.wdata, bus.be);
        MtimecmpLoOffset: mtimecmp_d[31:0]  = merge_be(mtimecmp_q[31:0], bus.wdata, bus.be);
        MtimecmpHiOffset: mtimecmp_d[63:32] = merge_be(mtimecmp_q[63:32], bus.wdata, bus.be);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // Interrupt off out of reset
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= mtime_q >= mtimecmp_q;
      rvalid_q   <= bus.req;
    end
  end

  // Read data sampled in the request cycle
  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      if (bus.we) begin
        rdata_q <= '0;
      end else begin
        case (reg_off)
          MtimeLoOffset:    rdata_q <= mtime_q[31:0];
          MtimeHiOffset:    rdata_q <= mtime_q[63:32];
          MtimecmpLoOffset: rdata_q <= mtimecmp_q[31:0];
          MtimecmpHiOffset: rdata_q <= mtimecmp_q[63:32];
          default:          rdata_q <= '0;
        endcase
      end
    end
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign timer_irq_o = irq_q;

  // Exactly one response per request, one cycle later
  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus.req |=> bus.rvalid ##1 (!bus.rvalid || $past(bus.req)));

endmodule

// ==== verilog/periph_subsys_top.sv ====
//////////////////////////////
// Peripheral subsystem top
// Decoder, GPIO, timer and RAM port
//////////////////////////////

`timescale 1ns/1ns

module periph_subsys_top #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  // Host port
  input  logic                host_req_i,
  input  sys_bus_pkg::addr_t  host_addr_i,
  input  logic                host_we_i,
  input  sys_bus_pkg::strb_t  host_be_i,
  input  sys_bus_pkg::data_t  host_wdata_i,
  output logic                host_gnt_o,
  output logic                host_rvalid_o,
  output sys_bus_pkg::data_t  host_rdata_o,
  output logic                host_err_o,

  // External RAM
  output logic                mem_req_o,
  output logic                mem_we_o,
  output sys_bus_pkg::strb_t  mem_be_o,
  output sys_bus_pkg::addr_t  mem_addr_o,
  output sys_bus_pkg::data_t  mem_wdata_o,
  input  logic                mem_rvalid_i,
  input  sys_bus_pkg::data_t  mem_rdata_i,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o,
  output logic                timer_irq_o
);

  dev_bus_if gpio_bus ();
  dev_bus_if timer_bus ();

  bus_decoder u_bus_decoder (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .gpio_bus      (gpio_bus),
    .timer_bus     (timer_bus),
    .mem_req_o     (mem_req_o),
    .mem_we_o      (mem_we_o),
    .mem_be_o      (mem_be_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  gpio_regs #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus        (gpio_bus),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  mtimer u_mtimer (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .bus         (timer_bus),
    .timer_irq_o (timer_irq_o)
  );

endmodule
